// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CAN frame generator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module can_frame_gen_tb --Mdir obj_dir -o can_frame_gen_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/can_frame_gen_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== source/can_frame_gen.sv ====
`timescale 1ns/1ps

module can_frame_gen
(
    input  logic                     clk,
    input  logic                     g_rst,
    // Start request.
    input  logic                     start_valid,
    output logic                     start_ready,
    input  can_frame_pkg::arb_t      arb,
    input  can_frame_pkg::ctrl_t     ctrl,
    input  can_frame_pkg::dlc_t      dlc,
    input  can_frame_pkg::payload_t  payload,
    input  can_frame_pkg::tail_t     tail,
    input  logic                     sec,
    // Header CRC engine.
    output logic                     hdr_valid,
    output can_frame_pkg::hdr_t      hdr_data,
    input  logic                     pcrc_valid,
    input  can_frame_pkg::pcrc_t     pcrc,
    // Frame CRC engine.
    output logic                     body_valid,
    output can_frame_pkg::body_t     body_data,
    input  logic                     fcrc_valid,
    input  can_frame_pkg::fcrc_t     fcrc,
    // To bit stuffing.
    output logic                     frame_valid,
    input  logic                     frame_ready,
    output can_frame_pkg::frm_t      frame_data,
    output can_frame_pkg::frm_len_t  frame_len
);

    import can_frame_pkg::*;

    logic     capture;
    logic     pcrc_load;
    logic     fcrc_load;
    logic     frame_load;
    dlc_t     bytes;
    payload_t payload_q;
    tail_t    tail_q;

    // ##################################################
    frame_ctrl ctrl_i
    (
        .clk         (clk),
        .g_rst       (g_rst),
        .start_valid (start_valid),
        .pcrc_valid  (pcrc_valid),
        .fcrc_valid  (fcrc_valid),
        .frame_ready (frame_ready),
        .start_ready (start_ready),
        .hdr_valid   (hdr_valid),
        .body_valid  (body_valid),
        .frame_valid (frame_valid),
        .capture     (capture),
        .pcrc_load   (pcrc_load),
        .fcrc_load   (fcrc_load),
        .frame_load  (frame_load)
    );

    frame_header header_i
    (
        .clk       (clk),
        .g_rst     (g_rst),
        .capture   (capture),
        .arb       (arb),
        .ctrl      (ctrl),
        .dlc       (dlc),
        .payload   (payload),
        .tail      (tail),
        .sec       (sec),
        .hdr_data  (hdr_data),
        .bytes     (bytes),
        .payload_q (payload_q),
        .tail_q    (tail_q)
    );

    frame_assembler assembler_i
    (
        .clk        (clk),
        .g_rst      (g_rst),
        .pcrc_load  (pcrc_load),
        .fcrc_load  (fcrc_load),
        .frame_load (frame_load),
        .hdr_data   (hdr_data),
        .bytes      (bytes),
        .payload_q  (payload_q),
        .tail_q     (tail_q),
        .pcrc       (pcrc),
        .fcrc       (fcrc),
        .body_data  (body_data),
        .frame_data (frame_data),
        .frame_len  (frame_len)
    );

endmodule

// ==== source/can_frame_params.svh ====
`ifndef CAN_FRAME_PARAMS_SVH
`define CAN_FRAME_PARAMS_SVH

// ##################################################
// Message field widths.
`define ARB_W      29   // Arbitration field.
`define CTRL_W     3    // Control field.
`define LEN_W      11   // Header length field.
`define DLC_W      4    // Byte count.
`define MAX_BYTES  8    // Largest payload in bytes.
`define TAIL_W     20   // Tail field.

// CRC results.
`define PCRC_W     13
`define FCRC_W     32

// ##################################################
// Frame sizes.
`define HDR_W      44   // SOF, arbitration, length, control.
`define BODY_W     121  // Header, header CRC, full payload.
`define FRM_W      173  // Body, frame CRC, tail.
`define FRM_FIXED  109  // Frame bits without payload.

`define SEC_TAG    16   // Authentication tag bytes.

`endif

// ==== source/can_frame_pkg.sv ====
`include "can_frame_params.svh"

package can_frame_pkg;

    // ##################################################
    // Message fields.
    typedef logic [`ARB_W-1:0]          arb_t;
    typedef logic [`CTRL_W-1:0]         ctrl_t;
    typedef logic [`LEN_W-1:0]          len_t;
    typedef logic [`DLC_W-1:0]          dlc_t;
    typedef logic [`MAX_BYTES*8-1:0]    payload_t;
    typedef logic [`TAIL_W-1:0]         tail_t;

    // CRC results.
    typedef logic [`PCRC_W-1:0]         pcrc_t;
    typedef logic [`FCRC_W-1:0]         fcrc_t;

    // ##################################################
    // Frame vectors.
    typedef logic [`HDR_W-1:0]          hdr_t;
    typedef logic [`BODY_W-1:0]         body_t;
    typedef logic [`FRM_W-1:0]          frm_t;
    typedef logic [7:0]                 frm_len_t;  // Up to 173 bits.

    typedef enum logic [2:0]
    {
        idle,
        hdr_crc,
        body_crc,
        assemble,
        hold
    } ctrl_state_t;

endpackage

// ==== source/frame_assembler.sv ====
`timescale 1ns/1ps
`include "can_frame_params.svh"

module frame_assembler
(
    input  logic                     clk,
    input  logic                     g_rst,
    input  logic                     pcrc_load,
    input  logic                     fcrc_load,
    input  logic                     frame_load,
    input  can_frame_pkg::hdr_t      hdr_data,
    input  can_frame_pkg::dlc_t      bytes,
    input  can_frame_pkg::payload_t  payload_q,
    input  can_frame_pkg::tail_t     tail_q,
    input  can_frame_pkg::pcrc_t     pcrc,
    input  can_frame_pkg::fcrc_t     fcrc,
    output can_frame_pkg::body_t     body_data,
    output can_frame_pkg::frm_t      frame_data,
    output can_frame_pkg::frm_len_t  frame_len
);

    import can_frame_pkg::*;

    pcrc_t      pcrc_q;
    fcrc_t      fcrc_q;
    logic [6:0] pay_bits;       // Payload length in bits, 0 to 64.
    payload_t   payload_mask;
    payload_t   payload_sel;
    frm_t       frame_head;
    frm_t       frame_trail;
    frm_t       frame_nxt;
    frm_len_t   frame_len_nxt;

    // ##################################################
    // CRC capture.
    always_ff @(posedge clk)
    begin
        if (pcrc_load)
            pcrc_q <= pcrc;
        if (fcrc_load)
            fcrc_q <= fcrc;
    end

    // Keep only the leading bytes of the payload.
    assign pay_bits     = {bytes, 3'b000};
    assign payload_mask = ~({(`MAX_BYTES*8){1'b1}} >> pay_bits);
    assign payload_sel  = payload_q & payload_mask;

    assign body_data = {hdr_data, pcrc_q, payload_sel};

    // ##################################################
    // Final frame.
    // Head holds header, pcrc and payload with zeros below.
    assign frame_head = {body_data, {(`FRM_W-`BODY_W){1'b0}}};

    // CRC and tail slide up against the last payload byte.
    // Ones below them are the recessive fill.
    assign frame_trail = {fcrc_q, tail_q, {(`FRM_W-`FCRC_W-`TAIL_W){1'b1}}}
                         >> (`HDR_W + `PCRC_W + pay_bits);

    assign frame_nxt     = frame_head | frame_trail;
    assign frame_len_nxt = frm_len_t'(`FRM_FIXED) + frm_len_t'(pay_bits);

    always_ff @(posedge clk)
    begin
        if (frame_load)
            frame_data <= frame_nxt;
    end

    always_ff @(posedge clk or posedge g_rst)
    begin
        if (g_rst)
        begin
            frame_len <= '0;
        end
        else if (frame_load)
        begin
            frame_len <= frame_len_nxt;
        end
    end

endmodule

// ==== source/frame_ctrl.sv ====
`timescale 1ns/1ps

module frame_ctrl
(
    input  logic clk,
    input  logic g_rst,
    input  logic start_valid,
    input  logic pcrc_valid,
    input  logic fcrc_valid,
    input  logic frame_ready,
    output logic start_ready,
    output logic hdr_valid,
    output logic body_valid,
    output logic frame_valid,
    output logic capture,
    output logic pcrc_load,
    output logic fcrc_load,
    output logic frame_load
);

    import can_frame_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    // Request valids straight from the state.
    assign start_ready = (state == idle);
    assign hdr_valid   = (state == hdr_crc);
    assign body_valid  = (state == body_crc);
    assign frame_valid = (state == hold);

    // ##################################################
    // Handshake strobes.
    assign capture    = start_valid & start_ready;
    assign pcrc_load  = pcrc_valid & hdr_valid;   // Stray pulses ignored.
    assign fcrc_load  = fcrc_valid & body_valid;
    assign frame_load = (state == assemble);

    always_ff @(posedge clk or posedge g_rst)
    begin
        if (g_rst)
        begin
            state <= idle;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            idle:
            begin
                if (capture)
                    state_nxt = hdr_crc;
            end
            hdr_crc:
            begin
                if (pcrc_load)
                    state_nxt = body_crc;
            end
            body_crc:
            begin
                if (fcrc_load)
                    state_nxt = assemble;
            end
            assemble:
            begin
                state_nxt = hold;   // Frame register loads here.
            end
            hold:
            begin
                if (frame_valid && frame_ready)
                    state_nxt = idle;
            end
            default:
            begin
                state_nxt = idle;
            end
        endcase
    end

endmodule

// ==== source/frame_header.sv ====
`timescale 1ns/1ps
`include "can_frame_params.svh"

module frame_header
(
    input  logic                     clk,
    input  logic                     g_rst,
    input  logic                     capture,
    input  can_frame_pkg::arb_t      arb,
    input  can_frame_pkg::ctrl_t     ctrl,
    input  can_frame_pkg::dlc_t      dlc,
    input  can_frame_pkg::payload_t  payload,
    input  can_frame_pkg::tail_t     tail,
    input  logic                     sec,
    output can_frame_pkg::hdr_t      hdr_data,
    output can_frame_pkg::dlc_t      bytes,
    output can_frame_pkg::payload_t  payload_q,
    output can_frame_pkg::tail_t     tail_q
);

    import can_frame_pkg::*;

    arb_t  arb_q;
    ctrl_t ctrl_q;
    logic  sec_q;
    dlc_t  bytes_clamp;
    len_t  len_field;

    // Anything above the largest payload counts as full.
    assign bytes_clamp = (dlc > dlc_t'(`MAX_BYTES)) ? dlc_t'(`MAX_BYTES) : dlc;

    always_ff @(posedge clk or posedge g_rst)
    begin
        if (g_rst)
        begin
            bytes <= '0;
            sec_q <= 1'b0;
        end
        else if (capture)
        begin
            bytes <= bytes_clamp;
            sec_q <= sec;
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            arb_q     <= arb;
            ctrl_q    <= ctrl;
            payload_q <= payload;
            tail_q    <= tail;
        end
    end

    // ##################################################
    // Header, MSB first.
    assign len_field = sec_q ? len_t'(bytes) + len_t'(`SEC_TAG) : len_t'(bytes);
    assign hdr_data  = {1'b0, arb_q, len_field, ctrl_q};  // Dominant SOF.

endmodule

// ==== testbench/can_frame_gen_tb.sv ====
`timescale 1ns/1ps
`include "can_frame_params.svh"

module can_frame_gen_tb;

    import can_frame_pkg::*;

    localparam int frames           = 40;
    localparam int cycles_per_frame = 60;
    localparam int clk_period       = 100;
    localparam int timeout_ns       = frames * cycles_per_frame * clk_period;

    // Reference model states.
    localparam int st_idle = 0;
    localparam int st_hdr  = 1;
    localparam int st_body = 2;
    localparam int st_asm  = 3;
    localparam int st_hold = 4;

    logic     clk;
    logic     g_rst;
    logic     start_valid;
    logic     start_ready;
    arb_t     arb;
    ctrl_t    ctrl;
    dlc_t     dlc;
    payload_t payload;
    tail_t    tail;
    logic     sec;
    logic     hdr_valid;
    hdr_t     hdr_data;
    logic     pcrc_valid;
    pcrc_t    pcrc;
    logic     body_valid;
    body_t    body_data;
    logic     fcrc_valid;
    fcrc_t    fcrc;
    logic     frame_valid;
    logic     frame_ready;
    frm_t     frame_data;
    frm_len_t frame_len;

    logic [31:0] lfsr;
    int          frames_sent;
    int          frames_done;
    int          hdr_wait;      // Idle CRC engine countdowns sit at -1.
    int          body_wait;
    int          exp_st;
    int          exp_n;
    hdr_t        exp_hdr;
    payload_t    exp_payload;
    tail_t       exp_tail;
    body_t       exp_body;
    frm_t        exp_frame;
    frm_len_t    exp_len;
    logic        was_hold;
    frm_t        held_frame;
    frm_len_t    held_len;

    can_frame_gen dut_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // ##################################################
    // Helpers.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic hdr_t header_of(input arb_t a, input ctrl_t c, input int n, input logic s);
        len_t len;
        len = len_t'(s ? n + `SEC_TAG : n);
        return {1'b0, a, len, c};
    endfunction

    function automatic body_t body_of(input hdr_t h, input pcrc_t p, input payload_t d,
                                      input int n);
        body_t b;
        b = {h, p, 64'd0};
        for (int i = 0; i < 8 * n; i++)
            b[63 - i] = d[63 - i];   // Leading bytes only.
        return b;
    endfunction

    function automatic frm_t frame_of(input body_t b, input fcrc_t f, input tail_t t,
                                      input int n);
        frm_t r;
        int   nb;
        r  = '1;                    // Recessive fill.
        nb = `HDR_W + `PCRC_W + 8 * n;
        for (int i = 0; i < nb; i++)
            r[`FRM_W - 1 - i] = b[`BODY_W - 1 - i];
        for (int i = 0; i < `FCRC_W; i++)
            r[`FRM_W - 1 - nb - i] = f[`FCRC_W - 1 - i];
        for (int i = 0; i < `TAIL_W; i++)
            r[`FRM_W - 1 - nb - `FCRC_W - i] = t[`TAIL_W - 1 - i];
        return r;
    endfunction

    task automatic abort_with(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at first error.");
    endtask

    task automatic flag_mismatch(input string name, input logic [191:0] got,
                                 input logic [191:0] exp);
        abort_with($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    // ##################################################
    // Model steps by the edge just passed; inputs still hold what was sampled.
    task advance_model;
        int nd;
        case (exp_st)
            st_idle:
            begin
                if (start_valid)
                begin
                    nd          = int'(dlc);
                    exp_n       = (nd > `MAX_BYTES) ? `MAX_BYTES : nd;
                    exp_hdr     = header_of(arb, ctrl, exp_n, sec);
                    exp_payload = payload;
                    exp_tail    = tail;
                    exp_st      = st_hdr;
                end
            end
            st_hdr:
            begin
                if (pcrc_valid)
                begin
                    exp_body = body_of(exp_hdr, pcrc, exp_payload, exp_n);
                    exp_st   = st_body;
                end
            end
            st_body:
            begin
                if (fcrc_valid)
                begin
                    exp_frame = frame_of(exp_body, fcrc, exp_tail, exp_n);
                    exp_len   = 8'(`FRM_FIXED + 8 * exp_n);
                    exp_st    = st_asm;
                end
            end
            st_asm:
                exp_st = st_hold;
            default:
            begin
                if (frame_ready)
                begin
                    exp_st      = st_idle;
                    frames_done = frames_done + 1;
                end
            end
        endcase
    endtask

    task check_outputs;
        assert (start_ready == (exp_st == st_idle))
            else flag_mismatch("start_ready", 192'(start_ready), 192'(exp_st == st_idle));
        assert (hdr_valid == (exp_st == st_hdr))
            else flag_mismatch("hdr_valid", 192'(hdr_valid), 192'(exp_st == st_hdr));
        assert (body_valid == (exp_st == st_body))
            else flag_mismatch("body_valid", 192'(body_valid), 192'(exp_st == st_body));
        assert (frame_valid == (exp_st == st_hold))
            else flag_mismatch("frame_valid", 192'(frame_valid), 192'(exp_st == st_hold));
        if (exp_st != st_idle)
            assert (hdr_data == exp_hdr)
                else flag_mismatch("hdr_data", 192'(hdr_data), 192'(exp_hdr));
        if (exp_st == st_body)
            assert (body_data == exp_body)
                else flag_mismatch("body_data", 192'(body_data), 192'(exp_body));
        if (exp_st == st_hold && was_hold)  // Back-pressure on the last edge.
        begin
            assert (frame_data == held_frame)
                else flag_mismatch("frame_data held", 192'(frame_data), 192'(held_frame));
            assert (frame_len == held_len)
                else flag_mismatch("frame_len held", 192'(frame_len), 192'(held_len));
        end
        if (exp_st == st_hold)
        begin
            assert (frame_data == exp_frame)
                else flag_mismatch("frame_data", 192'(frame_data), 192'(exp_frame));
            assert (frame_len == exp_len)
                else flag_mismatch("frame_len", 192'(frame_len), 192'(exp_len));
        end
        was_hold   = (exp_st == st_hold);
        held_frame = frame_data;
        held_len   = frame_len;
    endtask

    task drive_inputs;
        if (start_valid)
            start_valid = 1'b0;     // Taken on the last edge.
        else if (start_ready && frames_sent < frames && take_bits(1) == 64'd1)
        begin
            start_valid = 1'b1;
            arb         = arb_t'(take_bits(`ARB_W));
            ctrl        = ctrl_t'(take_bits(`CTRL_W));
            dlc         = dlc_t'(take_bits(`DLC_W));
            payload     = payload_t'(take_bits(64));
            tail        = tail_t'(take_bits(`TAIL_W));
            sec         = (take_bits(1) == 64'd1);
            frames_sent = frames_sent + 1;
        end

        // Header CRC engine.
        pcrc_valid = 1'b0;
        if (hdr_valid && hdr_wait < 0)
            hdr_wait = int'(take_bits(3));
        if (hdr_wait == 0)
        begin
            pcrc_valid = 1'b1;
            pcrc       = pcrc_t'(take_bits(`PCRC_W));
            hdr_wait   = -1;
        end
        else if (hdr_wait > 0)
            hdr_wait = hdr_wait - 1;
        else if (take_bits(3) == 64'd0)
        begin
            pcrc_valid = 1'b1;      // Stray pulse.
            pcrc       = pcrc_t'(take_bits(`PCRC_W));
        end

        // Frame CRC engine.
        fcrc_valid = 1'b0;
        if (body_valid && body_wait < 0)
            body_wait = int'(take_bits(3));
        if (body_wait == 0)
        begin
            fcrc_valid = 1'b1;
            fcrc       = fcrc_t'(take_bits(`FCRC_W));
            body_wait  = -1;
        end
        else if (body_wait > 0)
            body_wait = body_wait - 1;
        else if (take_bits(3) == 64'd0)
        begin
            fcrc_valid = 1'b1;
            fcrc       = fcrc_t'(take_bits(`FCRC_W));
        end

        frame_ready = (take_bits(1) == 64'd1);
    endtask

    // ##################################################
    initial
    begin
        clk         = 1'b0;
        g_rst       = 1'b1;
        start_valid = 1'b0;
        arb         = '0;
        ctrl        = '0;
        dlc         = '0;
        payload     = '0;
        tail        = '0;
        sec         = 1'b0;
        pcrc_valid  = 1'b0;
        pcrc        = '0;
        fcrc_valid  = 1'b0;
        fcrc        = '0;
        frame_ready = 1'b0;
        lfsr        = 32'he3e2;
        frames_sent = 0;
        frames_done = 0;
        hdr_wait    = -1;
        body_wait   = -1;
        exp_st      = st_idle;
        was_hold    = 1'b0;

        repeat (3) @(negedge clk);
        g_rst = 1'b0;

        while (frames_done < frames)
        begin
            @(negedge clk);
            advance_model();
            check_outputs();
            drive_inputs();
        end
        $display("NO ERRORS");
        $finish;
    end

    initial
    begin
        #(timeout_ns);
        abort_with("Watchdog timeout: not all frames were handed off in time.");
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/can_frame_pkg.sv
source/frame_ctrl.sv
source/frame_header.sv
source/frame_assembler.sv
source/can_frame_gen.sv
testbench/can_frame_gen_tb.sv
